//--- rtl/cpuCfgPkg.sv
package cpuCfgPkg;

    // Datapath width
    localparam int XLEN = 32;

    // Register index width, x0..x31
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 2 ** REG_AW; // Includes x0

    // Memory depths in 32-bit words
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;

    // Word address widths
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

endpackage

//--- rtl/rvIsaPkg.sv
package rvIsaPkg;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011; // ECALL only

    // funct3 codes
    localparam logic [2:0] F3_ADDSUB = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;
    localparam logic [2:0] F3_LW     = 3'b010; // Word width, shared by LW and SW

    // funct7 with bit 30 set marks SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // ALU operation codes
    localparam logic [3:0] ALU_ADD = 4'd0;
    localparam logic [3:0] ALU_SUB = 4'd1;
    localparam logic [3:0] ALU_AND = 4'd2;
    localparam logic [3:0] ALU_OR  = 4'd3;
    localparam logic [3:0] ALU_XOR = 4'd4;
    localparam logic [3:0] ALU_SLT = 4'd5;

    // One instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;  // imm[11:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;  // imm[4:0]
            logic [6:0] opcode;
        } sFmt;
        struct packed {
            logic       immSign; // imm[12]
            logic [5:0] immHi6;  // imm[10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] immLo4;  // imm[4:1]
            logic       imm11;   // imm[11]
            logic [6:0] opcode;
        } bFmt;
    } instr_u;

endpackage

//--- rtl/instrMem.sv
module instrMem (
    input  logic                              CLK,
    input  logic                              loadEn,
    input  logic [cpuCfgPkg::IMEM_AW-1:0]     loadAddr,
    input  logic [cpuCfgPkg::XLEN-1:0]        loadData,
    input  logic [cpuCfgPkg::IMEM_AW-1:0]     fetchAddr,
    output rvIsaPkg::instr_u                  instr
);
    import cpuCfgPkg::*;

    // Program storage, word addressed
    logic [XLEN-1:0] mem [IMEM_DEPTH];

    // Load port, one word per strobe
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    // Fetch is combinational so the whole instruction finishes in one cycle
    assign instr = mem[fetchAddr];

endmodule

//--- rtl/regFile.sv
module regFile (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic [cpuCfgPkg::REG_AW-1:0]  rs1,
    input  logic [cpuCfgPkg::REG_AW-1:0]  rs2,
    input  logic [cpuCfgPkg::REG_AW-1:0]  rd,
    input  logic [cpuCfgPkg::XLEN-1:0]    wrData,
    input  logic                          we,
    output logic [cpuCfgPkg::XLEN-1:0]    rdData1,
    output logic [cpuCfgPkg::XLEN-1:0]    rdData2
);
    import cpuCfgPkg::*;

    // x0..x31, entry 0 never written
    logic [NUM_REGS-1:0][XLEN-1:0] regs;

    always_ff @(posedge CLK) begin
        if (rst) begin
            regs <= '0;                    // Whole file cleared
        end else if (we && rd != '0) begin // x0 writes dropped
            regs[rd] <= wrData;
        end
    end

    // Read ports, x0 forced to zero
    assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

    // File only moves on a write strobe
    aRegsHoldWithoutWe: assert property (@(posedge CLK) !we && !rst |=> $stable(regs))
        else $error("regFile: register changed with we low");

endmodule

//--- rtl/decoder.sv
module decoder (
    input  rvIsaPkg::instr_u                  instr,
    input  logic                              running,
    output logic [cpuCfgPkg::REG_AW-1:0]      rs1,
    output logic [cpuCfgPkg::REG_AW-1:0]      rs2,
    output logic [cpuCfgPkg::REG_AW-1:0]      rd,
    output logic [cpuCfgPkg::XLEN-1:0]        imm,
    output logic [3:0]                        aluOp,
    output logic                              aluSrcImm,
    output logic                              regWe,
    output logic                              memWe,
    output logic                              memToReg,
    output logic                              isBranch,
    output logic                              branchOnEqual,
    output logic                              isHalt
);
    import rvIsaPkg::*;
    import cpuCfgPkg::*;

    logic wantReg; // Decoded write intent, before run gating
    logic wantMem;

    always_comb begin
        rs1           = instr.rFmt.rs1; // Same position in every format
        rs2           = '0;
        rd            = '0;
        imm           = '0;
        aluOp         = ALU_ADD;
        aluSrcImm     = 1'b0;
        wantReg       = 1'b0;
        wantMem       = 1'b0;
        memToReg      = 1'b0;
        isBranch      = 1'b0;
        branchOnEqual = 1'b0;
        isHalt        = 1'b0;
        case (instr.rFmt.opcode)
            OP_RTYPE: begin
                rs2     = instr.rFmt.rs2;
                rd      = instr.rFmt.rd;
                wantReg = 1'b1;
                case (instr.rFmt.funct3)
                    F3_ADDSUB: aluOp = (instr.rFmt.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_AND:    aluOp = ALU_AND;
                    F3_OR:     aluOp = ALU_OR;
                    F3_XOR:    aluOp = ALU_XOR;
                    F3_SLT:    aluOp = ALU_SLT;
                    default:   wantReg = 1'b0; // Shifts, SLTU not supported
                endcase
            end
            OP_ITYPE: begin // ADDI only
                rd        = instr.iFmt.rd;
                imm       = {{(XLEN-12){instr.iFmt.imm12[11]}}, instr.iFmt.imm12};
                aluSrcImm = 1'b1;
                wantReg   = (instr.iFmt.funct3 == F3_ADDSUB);
            end
            OP_LOAD: begin
                rd        = instr.iFmt.rd;
                imm       = {{(XLEN-12){instr.iFmt.imm12[11]}}, instr.iFmt.imm12};
                aluSrcImm = 1'b1;       // Address = rs1 + offset
                memToReg  = 1'b1;
                wantReg   = (instr.iFmt.funct3 == F3_LW);
            end
            OP_STORE: begin
                rs2       = instr.sFmt.rs2; // Store data
                imm       = {{(XLEN-12){instr.sFmt.immHi[6]}}, instr.sFmt.immHi,
                             instr.sFmt.immLo};
                aluSrcImm = 1'b1;
                wantMem   = (instr.sFmt.funct3 == F3_LW);
            end
            OP_BRANCH: begin
                rs2           = instr.bFmt.rs2;
                imm           = {{(XLEN-12){instr.bFmt.immSign}}, instr.bFmt.imm11,
                                 instr.bFmt.immHi6, instr.bFmt.immLo4, 1'b0};
                aluOp         = ALU_SUB; // Equality via zero flag
                isBranch      = (instr.bFmt.funct3 == F3_BEQ) ||
                                (instr.bFmt.funct3 == F3_BNE);
                branchOnEqual = (instr.bFmt.funct3 == F3_BEQ);
            end
            OP_SYSTEM: isHalt = 1'b1; // ECALL
            default: ;                // Unknown opcode, no side effects
        endcase
    end

    // Nothing commits unless the core is running
    assign regWe = wantReg && running;
    assign memWe = wantMem && running;

    // A single instruction never writes both the file and memory
    always_comb begin
        aNoDualWrite: assert (!(memWe && regWe))
            else $error("decoder: memWe and regWe both high");
    end

endmodule

//--- rtl/alu.sv
module alu (
    input  logic [cpuCfgPkg::XLEN-1:0]    opA,
    input  logic [cpuCfgPkg::XLEN-1:0]    opB,
    input  logic [3:0]                    aluOp,
    output logic [cpuCfgPkg::XLEN-1:0]    result,
    output logic                          zero
);
    import rvIsaPkg::*;
    import cpuCfgPkg::*;

    logic lessThan; // Signed compare for SLT

    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = opA + opB;
            ALU_SUB: result = opA - opB;   // Also drives branch compare
            ALU_AND: result = opA & opB;
            ALU_OR:  result = opA | opB;
            ALU_XOR: result = opA ^ opB;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lessThan};
            default: result = '0;
        endcase
    end

    // Equal operands under SUB
    assign zero = (result == '0);

endmodule

//--- rtl/dataMem.sv
module dataMem (
    input  logic                          CLK,
    input  logic [cpuCfgPkg::XLEN-1:0]    addr,
    input  logic                          we,
    input  logic [cpuCfgPkg::XLEN-1:0]    wrData,
    output logic [cpuCfgPkg::XLEN-1:0]    rdData
);
    import cpuCfgPkg::*;

    logic [XLEN-1:0]    mem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] wordAddr;

    // Byte address to word index, upper bits wrap
    assign wordAddr = addr[DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordAddr] <= wrData; // SW
        end
    end

    assign rdData = mem[wordAddr]; // LW, same cycle

    // Word stores only
    aStoreAligned: assert property (@(posedge CLK) we |-> addr[1:0] == 2'b00)
        else $error("dataMem: misaligned store to %h", addr);

endmodule

//--- rtl/singleCpu.sv
module singleCpu (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              loadEn,
    input  logic [cpuCfgPkg::IMEM_AW-1:0]     loadAddr,
    input  logic [cpuCfgPkg::XLEN-1:0]        loadData,
    input  logic                              startEn,
    output logic                              running,
    output logic                              halted,
    output logic                              retireValid,
    output logic [cpuCfgPkg::XLEN-1:0]        retirePc,
    output logic                              retireWrite,
    output logic [cpuCfgPkg::REG_AW-1:0]      retireRd,
    output logic [cpuCfgPkg::XLEN-1:0]        retireData
);
    import rvIsaPkg::*;
    import cpuCfgPkg::*;

    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   nextPc;
    instr_u            instr;
    logic [REG_AW-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]   imm;
    logic [3:0]        aluOp;
    logic              aluSrcImm, regWe, memWe, memToReg;
    logic              isBranch, branchOnEqual, isHalt;
    logic [XLEN-1:0]   rdData1, rdData2;
    logic [XLEN-1:0]   aluB, aluResult, memRdData, wbData;
    logic              zero;
    logic              takeBranch;

    instrMem instrMem_i (
        .CLK(CLK),
        .loadEn(loadEn && !running), // No loads mid-program
        .loadAddr(loadAddr),
        .loadData(loadData),
        .fetchAddr(pc[IMEM_AW+1:2]),
        .instr(instr)
    );

    decoder decoder_i (
        .instr(instr), .running(running),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm),
        .regWe(regWe), .memWe(memWe), .memToReg(memToReg),
        .isBranch(isBranch), .branchOnEqual(branchOnEqual), .isHalt(isHalt)
    );

    regFile regFile_i (
        .CLK(CLK), .rst(rst),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .wrData(wbData), .we(regWe),
        .rdData1(rdData1), .rdData2(rdData2)
    );

    assign aluB = aluSrcImm ? imm : rdData2; // Immediate or rs2

    alu alu_i (.opA(rdData1), .opB(aluB), .aluOp(aluOp), .result(aluResult), .zero(zero));

    dataMem dataMem_i (
        .CLK(CLK), .addr(aluResult), .we(memWe), .wrData(rdData2), .rdData(memRdData)
    );

    assign wbData = memToReg ? memRdData : aluResult;

    // BEQ takes on zero, BNE on nonzero
    assign takeBranch = isBranch && (zero == branchOnEqual);
    assign nextPc     = takeBranch ? pc + imm : pc + XLEN'(4);

    // PC and run/halt control
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc          <= '0;
            running     <= 1'b0;
            halted      <= 1'b0;
            retireValid <= 1'b0;
            retireWrite <= 1'b0;
        end else begin
            retireValid <= running;                   // One strobe per executed instr
            retireWrite <= regWe && (rd != '0);       // Already gated by running
            if (startEn && !running) begin
                pc      <= '0;
                running <= 1'b1;
                halted  <= 1'b0;
            end else if (running) begin
                if (isHalt) begin                     // ECALL stops here
                    running <= 1'b0;
                    halted  <= 1'b1;
                end else begin
                    pc <= nextPc;
                end
            end
        end
    end

    // Retire payload, meaningful only with retireValid
    always_ff @(posedge CLK) begin
        if (running) begin
            retirePc   <= pc;
            retireRd   <= rd;
            retireData <= wbData;
        end
    end

    // Branch offsets keep the PC on word boundaries
    aPcAligned: assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00)
        else $error("singleCpu: misaligned pc %h", pc);

endmodule

//--- dv/singleCpuTb.sv
module singleCpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuCfgPkg::*;

    localparam string TEST_FILE  = "dv/cpuTests.txt";
    localparam int    CLK_PERIOD = 100;
    localparam int    RST_CYCLES = 8;

    logic                CLK = 1'b0;
    logic                rst;
    logic                loadEn;
    logic [IMEM_AW-1:0]  loadAddr;
    logic [XLEN-1:0]     loadData;
    logic                startEn;
    logic                running;
    logic                halted;
    logic                retireValid;
    logic [XLEN-1:0]     retirePc;
    logic                retireWrite;
    logic [REG_AW-1:0]   retireRd;
    logic [XLEN-1:0]     retireData;

    // Test file contents, one entry per T record
    string               testName[$];
    int                  progFirst[$];
    int                  progCount[$];
    int                  expFirst[$];
    int                  expCount[$];
    logic [XLEN-1:0]     progWords[$];   // All P words back to back
    logic [REG_AW-1:0]   expRd[$];
    logic [XLEN-1:0]     expVal[$];

    int                  testErrors;     // Failures in the current test
    int                  passCount;
    int                  failCount;
    int                  limitCycles;
    bit                  fileOk;

    singleCpu singleCpu_i (
        .CLK(CLK), .rst(rst),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .startEn(startEn), .running(running), .halted(halted),
        .retireValid(retireValid), .retirePc(retirePc), .retireWrite(retireWrite),
        .retireRd(retireRd), .retireData(retireData)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Drops the rest of a comment line
    task automatic skipLine(input int fd);
        int c;
        c = 0;
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic readTests(output bit ok);
        int              fd;
        int              n;
        int              rdIdx;
        string           tag;
        string           name;
        logic [XLEN-1:0] word;
        ok = 1'b1;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s", TEST_FILE);
            ok = 1'b0;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                skipLine(fd);
            end else if (tag == "T") begin
                n = $fscanf(fd, "%s", name);
                testName.push_back(name);
                progFirst.push_back(progWords.size());
                expFirst.push_back(expRd.size());
            end else if (tag == "P") begin
                n = $fscanf(fd, "%h", word);
                if (n != 1) ok = 1'b0;
                progWords.push_back(word);
            end else if (tag == "E") begin
                n = $fscanf(fd, "%d %h", rdIdx, word);
                if (n != 2) ok = 1'b0;
                expRd.push_back(rdIdx[REG_AW-1:0]);
                expVal.push_back(word);
            end else if (tag == "H") begin  // Closes the open test
                progCount.push_back(progWords.size() - progFirst[$]);
                expCount.push_back(expRd.size() - expFirst[$]);
            end else begin
                $display("Unknown record %s in %s", tag, TEST_FILE);
                ok = 1'b0;
            end
        end
        $fclose(fd);
        if (testName.size() == 0 || progCount.size() != testName.size()) begin
            $display("Test file %s has no tests or a test without H", TEST_FILE);
            ok = 1'b0;
        end
    endtask

    task automatic checkReg(input logic [REG_AW-1:0] got, input logic [REG_AW-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, rd x%0d, expected x%0d", $time, what, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkWord(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, data %h, expected %h", $time, what, got, exp);
            testErrors++;
        end
    endtask

    // Whole run bounded by the program sizes
    task automatic watchdog(input int cycles);
        #(cycles * CLK_PERIOD);
        $display("Timeout after %0d cycles, the processor never finished the tests", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic runTest(input int t);
        int    expIdx;
        int    expEnd;
        string what;
        bit    seenRetire;
        testErrors = 0;
        seenRetire = 1'b0;
        for (int i = 0; i < progCount[t]; i++) begin  // One word per cycle
            @(negedge CLK);
            loadEn   = 1'b1;
            loadAddr = IMEM_AW'(i);
            loadData = progWords[progFirst[t] + i];
        end
        @(negedge CLK);
        loadEn  = 1'b0;
        startEn = 1'b1;
        @(negedge CLK);
        startEn = 1'b0;
        expIdx  = expFirst[t];
        expEnd  = expFirst[t] + expCount[t];
        while (!halted) begin
            @(negedge CLK);
            if (retireValid && !seenRetire) begin  // Execution begins at address 0
                checkWord(retirePc, '0, $sformatf("%s first retire pc", testName[t]));
                seenRetire = 1'b1;
            end
            if (retireValid && retireWrite) begin
                if (expIdx >= expEnd) begin
                    $display("Test %s: extra register write x%0d = %h from pc %h",
                             testName[t], retireRd, retireData, retirePc);
                    testErrors++;
                end else begin
                    what = $sformatf("%s write %0d at pc %h", testName[t],
                                     expIdx - expFirst[t], retirePc);
                    checkReg(retireRd, expRd[expIdx], what);
                    checkWord(retireData, expVal[expIdx], what);
                    expIdx++;
                end
            end
        end
        // ECALL is the last loaded word, reported in the cycle halted rises
        if (!retireValid) begin
            $display("Test %s: ECALL was not reported on the retire ports", testName[t]);
            testErrors++;
        end else begin
            checkWord(retirePc, XLEN'((progCount[t] - 1) * 4),
                      $sformatf("%s halt pc", testName[t]));
        end
        if (expIdx < expEnd) begin
            $display("Test %s: %0d expected register writes never happened",
                     testName[t], expEnd - expIdx);
            testErrors++;
        end
        @(negedge CLK);  // ECALL retire has passed by now
        if (retireValid || running) begin
            $display("Test %s: processor kept running after ECALL", testName[t]);
            testErrors++;
        end
        if (testErrors == 0) begin
            passCount++;
            $display("Test %s passed", testName[t]);
        end else begin
            failCount++;
            $display("Test %s failed with %0d errors", testName[t], testErrors);
        end
    endtask

    initial begin
        rst       = 1'b1;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        startEn   = 1'b0;
        passCount = 0;
        failCount = 0;
        readTests(fileOk);
        if (!fileOk) begin
            $display("Test file unusable, no test was run");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            limitCycles = progWords.size() * 4 + 50;
            fork
                watchdog(limitCycles);
            join_none
            repeat (RST_CYCLES) @(negedge CLK);
            rst = 1'b0;
            foreach (testName[t]) begin
                runTest(t);
            end
            $display("Tests passed: %0d, failed: %0d", passCount, failCount);
            if (failCount == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

//--- dv/cpuTests.txt
# Records: T name, P instruction word in hex, E rd in decimal and write value in hex, H halt
# E records give the register writes in retire order, text after # is ignored
T arith
P 00700093 E 1 00000007  # addi x1, x0, 7
P ffd00113 E 2 fffffffd  # addi x2, x0, -3
P 002081b3 E 3 00000004  # add  x3, x1, x2
P 40208233 E 4 0000000a  # sub  x4, x1, x2    7 - (-3)
P 0020f2b3 E 5 00000005  # and  x5, x1, x2
P 0020e333 E 6 ffffffff  # or   x6, x1, x2
P 0020c3b3 E 7 fffffffa  # xor  x7, x1, x2
P 0020a433 E 8 00000000  # slt  x8, x1, x2    7 < -3 false
P 001124b3 E 9 00000001  # slt  x9, x2, x1    -3 < 7 true
P ff800513 E 10 fffffff8 # addi x10, x0, -8
P 002525b3 E 11 00000001 # slt  x11, x10, x2  -8 < -3 true
P 00000073               # ecall
H
T zeroReg
P 00500013               # addi x0, x0, 5    dropped
P 00c00093 E 1 0000000c  # addi x1, x0, 12
P 00100133 E 2 0000000c  # add  x2, x0, x1
P 000081b3 E 3 0000000c  # add  x3, x1, x0
P 00000073               # ecall
H
T memory
P 12300093 E 1 00000123  # addi x1, x0, 0x123
P fff00113 E 2 ffffffff  # addi x2, x0, -1
P 00102423               # sw   x1, 8(x0)
P 00202623               # sw   x2, 12(x0)
P 00802183 E 3 00000123  # lw   x3, 8(x0)
P 00c02203 E 4 ffffffff  # lw   x4, 12(x0)
P 00400293 E 5 00000004  # addi x5, x0, 4
P 0042a303 E 6 00000123  # lw   x6, 4(x5)
P fe22ae23               # sw   x2, -4(x5)
P 00002383 E 7 ffffffff  # lw   x7, 0(x0)
P 00000073               # ecall
H
T branch
P 00300093               # 0   addi x1, x0, 3
P 00000113               # 4   addi x2, x0, 0
P 00510113               # 8   addi x2, x2, 5    loop body
P fff08093               # 12  addi x1, x1, -1
P fe009ce3               # 16  bne  x1, x0, -8   back to 8 until x1 is 0
P 00008463               # 20  beq  x1, x0, +8   taken, skips 24
P 06300193               # 24  addi x3, x0, 99
P 00211463               # 28  bne  x2, x2, +8   not taken
P 00100213               # 32  addi x4, x0, 1
P 00208463               # 36  beq  x1, x2, +8   not taken
P 00200293               # 40  addi x5, x0, 2
P 00000073               # 44  ecall
E 1 00000003 E 2 00000000
E 2 00000005 E 1 00000002  # three loop passes
E 2 0000000a E 1 00000001
E 2 0000000f E 1 00000000
E 4 00000001 E 5 00000002
H
T restart
P 00510333 E 6 00000011  # add  x6, x2, x5    registers kept from branch test
P 004183b3 E 7 00000124  # add  x7, x3, x4    x3 still 0x123 from memory test
P 00802403 E 8 00000123  # lw   x8, 8(x0)     data memory kept as well
P 00000073               # ecall
H

//--- filelist.f
rtl/cpuCfgPkg.sv
rtl/rvIsaPkg.sv
rtl/instrMem.sv
rtl/regFile.sv
rtl/decoder.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/singleCpu.sv
dv/singleCpuTb.sv

//--- Makefile
# Verilator build and run for the single-cycle RV32I subset core

VERILATOR ?= verilator
TOP       ?= singleCpuTb
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= filelist.f

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "No result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
